// ==== logic/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define XLEN        64
`define DMEM_WORDS  512
// word index width of the data RAM
`define DMEM_AW     9
`define RESET_PC    64'h0000_0000_0000_0000

`endif

// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // one value per supported instruction
    typedef enum logic [5:0] {
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_LD,
        OP_SB, OP_SH, OP_SW, OP_SD,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDIW, OP_ADDW, OP_SUBW,
        OP_MUL, OP_MULW, OP_DIVU, OP_REMU, OP_DIVW, OP_REMW,
        OP_EBREAK, OP_ILLEGAL
    } rv_op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_mode_e;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD,
        MEM_DOUBLE
    } mem_size_e;

endpackage

`default_nettype wire

// ==== logic/inst_decode.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module inst_decode import rv_pkg::*; (
    input  wire [31:0]         inst,
    output rv_op_e             op,
    output logic [4:0]         rd,
    output logic [4:0]         rs1,
    output logic [4:0]         rs2,
    output logic [`XLEN-1:0]   imm_i,
    output logic [`XLEN-1:0]   imm_s,
    output logic [`XLEN-1:0]   imm_b,
    output logic [`XLEN-1:0]   imm_u,
    output logic [`XLEN-1:0]   imm_j,
    output logic [5:0]         shamt
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rd    = inst[11:7];
    assign rs1   = inst[19:15];
    assign rs2   = inst[24:20];
    assign shamt = inst[25:20];

    assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        op = OP_ILLEGAL;
        case (opcode)
            7'b0110111: op = OP_LUI;
            7'b0010111: op = OP_AUIPC;
            7'b1101111: op = OP_JAL;
            7'b1100111: if (funct3 == 3'b000) op = OP_JALR;
            7'b1100011: begin
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            7'b0000011: begin
                case (funct3)
                    3'b000:  op = OP_LB;
                    3'b001:  op = OP_LH;
                    3'b010:  op = OP_LW;
                    3'b011:  op = OP_LD;
                    3'b100:  op = OP_LBU;
                    3'b101:  op = OP_LHU;
                    3'b110:  op = OP_LWU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            7'b0100011: begin
                case (funct3)
                    3'b000:  op = OP_SB;
                    3'b001:  op = OP_SH;
                    3'b010:  op = OP_SW;
                    3'b011:  op = OP_SD;
                    default: op = OP_ILLEGAL;
                endcase
            end
            7'b0010011: begin
                case (funct3)
                    3'b000: op = OP_ADDI;
                    3'b010: op = OP_SLTI;
                    3'b011: op = OP_SLTIU;
                    3'b100: op = OP_XORI;
                    3'b110: op = OP_ORI;
                    3'b111: op = OP_ANDI;
                    // six-bit shamt leaves funct6 in the top bits
                    3'b001: if (funct7[6:1] == 6'b000000) op = OP_SLLI;
                    3'b101: begin
                        if (funct7[6:1] == 6'b000000) begin
                            op = OP_SRLI;
                        end else if (funct7[6:1] == 6'b010000) begin
                            op = OP_SRAI;
                        end
                    end
                    default: op = OP_ILLEGAL;
                endcase
            end
            7'b0110011: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = OP_ADD;
                    10'b0100000_000: op = OP_SUB;
                    10'b0000000_001: op = OP_SLL;
                    10'b0000000_010: op = OP_SLT;
                    10'b0000000_011: op = OP_SLTU;
                    10'b0000000_100: op = OP_XOR;
                    10'b0000000_101: op = OP_SRL;
                    10'b0100000_101: op = OP_SRA;
                    10'b0000000_110: op = OP_OR;
                    10'b0000000_111: op = OP_AND;
                    10'b0000001_000: op = OP_MUL;
                    10'b0000001_101: op = OP_DIVU;
                    10'b0000001_111: op = OP_REMU;
                    default:         op = OP_ILLEGAL;
                endcase
            end
            7'b0011011: if (funct3 == 3'b000) op = OP_ADDIW;
            7'b0111011: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = OP_ADDW;
                    10'b0100000_000: op = OP_SUBW;
                    10'b0000001_000: op = OP_MULW;
                    10'b0000001_100: op = OP_DIVW;
                    10'b0000001_110: op = OP_REMW;
                    default:         op = OP_ILLEGAL;
                endcase
            end
            7'b1110011: if (inst == 32'h0010_0073) op = OP_EBREAK;
            default: op = OP_ILLEGAL;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module reg_file (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               wen,
    input  wire [4:0]         waddr,
    input  wire [`XLEN-1:0]   wdata,
    input  wire [4:0]         raddr_a,
    input  wire [4:0]         raddr_b,
    output logic [`XLEN-1:0]  rdata_a,
    output logic [`XLEN-1:0]  rdata_b
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module alu import rv_pkg::*; (
    input  var alu_mode_e      mode,
    input  wire [`XLEN-1:0]    a,
    input  wire [`XLEN-1:0]    b,
    output logic [`XLEN-1:0]   result
);

    logic [5:0] sh;

    // RV64 shifts use six bits of b
    assign sh = b[5:0];

    always_comb begin
        case (mode)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << sh;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> sh;
            ALU_SRA:  result = $signed(a) >>> sh;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/lsu_align.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module lsu_align import rv_pkg::*; (
    input  var mem_size_e      size,
    input  wire                is_signed,
    input  wire [2:0]          offset,
    input  wire [`XLEN-1:0]    store_src,
    input  wire [`XLEN-1:0]    load_word,
    output logic [`XLEN-1:0]   store_data,
    output logic [7:0]         store_mask,
    output logic [`XLEN-1:0]   load_value
);

    logic [7:0]       base_mask;
    logic [`XLEN-1:0] lane;

    always_comb begin
        case (size)
            MEM_BYTE: base_mask = 8'h01;
            MEM_HALF: base_mask = 8'h03;
            MEM_WORD: base_mask = 8'h0f;
            default:  base_mask = 8'hff;
        endcase
    end

    // accesses are assumed to stay inside one 64-bit word
    assign store_data = store_src << {offset, 3'b000};
    assign store_mask = base_mask << offset;

    assign lane = load_word >> {offset, 3'b000};

    always_comb begin
        case (size)
            MEM_BYTE: load_value = {{(`XLEN-8){is_signed & lane[7]}}, lane[7:0]};
            MEM_HALF: load_value = {{(`XLEN-16){is_signed & lane[15]}}, lane[15:0]};
            MEM_WORD: load_value = {{(`XLEN-32){is_signed & lane[31]}}, lane[31:0]};
            default:  load_value = lane;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module data_ram (
    input  wire                  clk,
    input  wire                  wen,
    input  wire [`DMEM_AW-1:0]   addr,
    input  wire [`XLEN-1:0]      wdata,
    input  wire [7:0]            wmask,
    output logic [`XLEN-1:0]     rdata
);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];

    initial begin
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // one enable per byte lane
    always_ff @(posedge clk) begin
        if (wen) begin
            for (int b = 0; b < 8; b++) begin
                if (wmask[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    assign rdata = mem[addr];

endmodule

`default_nettype wire

// ==== logic/exec_unit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module exec_unit import rv_pkg::*; (
    input  var rv_op_e            op,
    input  wire [4:0]             rd,
    input  wire [5:0]             shamt,
    input  wire [`XLEN-1:0]       imm_i,
    input  wire [`XLEN-1:0]       imm_s,
    input  wire [`XLEN-1:0]       imm_b,
    input  wire [`XLEN-1:0]       imm_u,
    input  wire [`XLEN-1:0]       imm_j,
    input  wire [`XLEN-1:0]       pc,
    input  wire [`XLEN-1:0]       rs1_data,
    input  wire [`XLEN-1:0]       rs2_data,
    input  wire [`XLEN-1:0]       mem_rdata,
    output logic                  wb_en,
    output logic [`XLEN-1:0]      wb_data,
    output logic [`DMEM_AW-1:0]   mem_addr,
    output logic [`XLEN-1:0]      mem_wdata,
    output logic [7:0]            mem_wmask,
    output logic                  mem_wen,
    output logic [`XLEN-1:0]      dnpc,
    output logic                  is_ebreak
);

    alu_mode_e          alu_mode;
    logic [`XLEN-1:0]   alu_a;
    logic [`XLEN-1:0]   alu_b;
    logic [`XLEN-1:0]   alu_y;
    logic [`XLEN-1:0]   snpc;
    logic [`XLEN-1:0]   br_target;
    logic               br_taken;
    logic               writes_rd;
    mem_size_e          mem_size;
    logic               load_signed;
    logic [`XLEN-1:0]   load_value;
    logic [`XLEN-1:0]   mul_y;
    logic [`XLEN-1:0]   divu_y;
    logic [`XLEN-1:0]   remu_y;
    logic signed [31:0] dw_a;
    logic signed [31:0] dw_b;
    logic signed [31:0] dw_d;
    logic signed [31:0] dw_q;
    logic signed [31:0] dw_r;
    logic               dw_zero;
    logic               dw_ovf;

    function automatic logic [`XLEN-1:0] sext32(input logic [31:0] v);
        return {{(`XLEN-32){v[31]}}, v};
    endfunction

    always_comb begin
        case (op)
            OP_SUB, OP_SUBW, OP_BEQ, OP_BNE:     alu_mode = ALU_SUB;
            OP_SLT, OP_SLTI, OP_BLT, OP_BGE:     alu_mode = ALU_SLT;
            OP_SLTU, OP_SLTIU, OP_BLTU, OP_BGEU: alu_mode = ALU_SLTU;
            OP_XOR, OP_XORI:                     alu_mode = ALU_XOR;
            OP_OR, OP_ORI:                       alu_mode = ALU_OR;
            OP_AND, OP_ANDI:                     alu_mode = ALU_AND;
            OP_SLL, OP_SLLI:                     alu_mode = ALU_SLL;
            OP_SRL, OP_SRLI:                     alu_mode = ALU_SRL;
            OP_SRA, OP_SRAI:                     alu_mode = ALU_SRA;
            default:                             alu_mode = ALU_ADD;
        endcase
    end

    assign alu_a = (op == OP_AUIPC || op == OP_JAL) ? pc : rs1_data;

    always_comb begin
        case (op)
            OP_AUIPC:                       alu_b = imm_u;
            OP_JAL:                         alu_b = imm_j;
            OP_SB, OP_SH, OP_SW, OP_SD:     alu_b = imm_s;
            OP_SLLI, OP_SRLI, OP_SRAI:      alu_b = {{(`XLEN-6){1'b0}}, shamt};
            OP_JALR, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_LD,
            OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_ADDIW:
                                            alu_b = imm_i;
            default:                        alu_b = rs2_data;
        endcase
    end

    alu u_alu (
        .mode   (alu_mode),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_y)
    );

    // a zero divisor gives all ones and the dividend
    assign mul_y  = rs1_data * rs2_data;
    assign divu_y = (rs2_data == '0) ? '1 : rs1_data / rs2_data;
    assign remu_y = (rs2_data == '0) ? rs1_data : rs1_data % rs2_data;

    assign dw_a    = rs1_data[31:0];
    assign dw_b    = rs2_data[31:0];
    assign dw_zero = (dw_b == 32'sd0);
    assign dw_ovf  = (dw_a == 32'sh8000_0000) && (dw_b == -32'sd1);
    // dividing by one covers the overflow case too
    assign dw_d    = (dw_zero || dw_ovf) ? 32'sd1 : dw_b;
    assign dw_q    = dw_zero ? -32'sd1 : dw_a / dw_d;
    assign dw_r    = dw_zero ? dw_a : dw_a % dw_d;

    always_comb begin
        case (op)
            OP_LB, OP_LBU, OP_SB: mem_size = MEM_BYTE;
            OP_LH, OP_LHU, OP_SH: mem_size = MEM_HALF;
            OP_LW, OP_LWU, OP_SW: mem_size = MEM_WORD;
            default:              mem_size = MEM_DOUBLE;
        endcase
    end

    assign load_signed = (op == OP_LB) || (op == OP_LH) || (op == OP_LW);
    assign mem_wen     = (op == OP_SB) || (op == OP_SH) || (op == OP_SW) || (op == OP_SD);
    assign mem_addr    = alu_y[`DMEM_AW+2:3];

    lsu_align u_lsu (
        .size       (mem_size),
        .is_signed  (load_signed),
        .offset     (alu_y[2:0]),
        .store_src  (rs2_data),
        .load_word  (mem_rdata),
        .store_data (mem_wdata),
        .store_mask (mem_wmask),
        .load_value (load_value)
    );

    always_comb begin
        writes_rd = 1'b1;
        case (op)
            OP_LUI:                                  wb_data = imm_u;
            OP_JAL, OP_JALR:                         wb_data = snpc;
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_LD:
                                                     wb_data = load_value;
            OP_ADDIW, OP_ADDW, OP_SUBW:              wb_data = sext32(alu_y[31:0]);
            OP_MUL:                                  wb_data = mul_y;
            OP_MULW:                                 wb_data = sext32(mul_y[31:0]);
            OP_DIVU:                                 wb_data = divu_y;
            OP_REMU:                                 wb_data = remu_y;
            OP_DIVW:                                 wb_data = sext32(dw_q);
            OP_REMW:                                 wb_data = sext32(dw_r);
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
            OP_SB, OP_SH, OP_SW, OP_SD, OP_EBREAK, OP_ILLEGAL: begin
                writes_rd = 1'b0;
                wb_data   = alu_y;
            end
            default:                                 wb_data = alu_y;
        endcase
    end

    assign wb_en = writes_rd && (rd != 5'd0);

    // next pc
    assign snpc      = pc + `XLEN'(4);
    assign br_target = pc + imm_b;

    always_comb begin
        case (op)
            OP_BEQ:           br_taken = (alu_y == '0);
            OP_BNE:           br_taken = (alu_y != '0);
            OP_BLT, OP_BLTU:  br_taken = alu_y[0];
            OP_BGE, OP_BGEU:  br_taken = !alu_y[0];
            default:          br_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            OP_JAL:    dnpc = alu_y;
            OP_JALR:   dnpc = {alu_y[`XLEN-1:1], 1'b0};
            OP_EBREAK: dnpc = pc;
            default:   dnpc = br_taken ? br_target : snpc;
        endcase
    end

    assign is_ebreak = (op == OP_EBREAK);

endmodule

`default_nettype wire

// ==== logic/core_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module core_top import rv_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire [31:0]        inst,
    output logic [`XLEN-1:0]  pc,
    output logic              retire_valid,
    output logic [4:0]        retire_rd,
    output logic [`XLEN-1:0]  retire_data,
    output logic              halt,
    output logic              halt_code
);

    rv_op_e              dec_op;
    logic [4:0]          dec_rd;
    logic [4:0]          dec_rs1;
    logic [4:0]          dec_rs2;
    logic [`XLEN-1:0]    imm_i;
    logic [`XLEN-1:0]    imm_s;
    logic [`XLEN-1:0]    imm_b;
    logic [`XLEN-1:0]    imm_u;
    logic [`XLEN-1:0]    imm_j;
    logic [5:0]          shamt;
    logic [4:0]          rf_raddr_a;
    logic [`XLEN-1:0]    rs1_data;
    logic [`XLEN-1:0]    rs2_data;
    logic                ex_wb_en;
    logic [`XLEN-1:0]    wb_data;
    logic [`DMEM_AW-1:0] mem_addr;
    logic [`XLEN-1:0]    mem_wdata;
    logic [7:0]          mem_wmask;
    logic                mem_wen;
    logic [`XLEN-1:0]    mem_rdata;
    logic [`XLEN-1:0]    dnpc;
    logic                is_ebreak;
    logic                run;

    assign run = rst_n && !halt;

    // EBREAK reads a0 on port a for the exit code
    assign rf_raddr_a = is_ebreak ? 5'd10 : dec_rs1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= `RESET_PC;
            halt      <= 1'b0;
            halt_code <= 1'b0;
        end else if (!halt) begin
            pc <= dnpc;
            if (is_ebreak) begin
                halt      <= 1'b1;
                halt_code <= (rs1_data != '0);
            end
        end
    end

    assign retire_valid = ex_wb_en && run;
    assign retire_rd    = dec_rd;
    assign retire_data  = wb_data;

    inst_decode u_dec (
        .inst  (inst),
        .op    (dec_op),
        .rd    (dec_rd),
        .rs1   (dec_rs1),
        .rs2   (dec_rs2),
        .imm_i (imm_i),
        .imm_s (imm_s),
        .imm_b (imm_b),
        .imm_u (imm_u),
        .imm_j (imm_j),
        .shamt (shamt)
    );

    reg_file u_rf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wen     (retire_valid),
        .waddr   (dec_rd),
        .wdata   (wb_data),
        .raddr_a (rf_raddr_a),
        .raddr_b (dec_rs2),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data)
    );

    exec_unit u_exu (
        .op        (dec_op),
        .rd        (dec_rd),
        .shamt     (shamt),
        .imm_i     (imm_i),
        .imm_s     (imm_s),
        .imm_b     (imm_b),
        .imm_u     (imm_u),
        .imm_j     (imm_j),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .mem_rdata (mem_rdata),
        .wb_en     (ex_wb_en),
        .wb_data   (wb_data),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wmask (mem_wmask),
        .mem_wen   (mem_wen),
        .dnpc      (dnpc),
        .is_ebreak (is_ebreak)
    );

    data_ram u_dmem (
        .clk   (clk),
        .wen   (mem_wen && run),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .wmask (mem_wmask),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD / 2);
        clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== tb/core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module core_tb;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_ROWS = 64;

    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OP32  = 7'b0111011;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;

    logic              clk;
    logic              rst_n;
    logic [31:0]       inst;
    logic [`XLEN-1:0]  pc;
    logic              retire_valid;
    logic [4:0]        retire_rd;
    logic [`XLEN-1:0]  retire_data;
    logic              halt;
    logic              halt_code;

    // instruction memory holding one word per 4 bytes of pc
    logic [31:0]       prog [64];

    logic [`XLEN-1:0]  exp_pc [MAX_ROWS];
    logic              exp_valid [MAX_ROWS];
    logic [4:0]        exp_rd [MAX_ROWS];
    logic [`XLEN-1:0]  exp_data [MAX_ROWS];
    logic [`XLEN-1:0]  at;
    logic [`XLEN-1:0]  last_pc;
    int                n_rows;
    int                errors;
    int                checks;
    bit                table_done;

    clock_gen #(.PERIOD(CLK_PERIOD)) u_clk (.clk(clk));

    // nop while in reset, otherwise the word at pc
    assign inst = rst_n ? prog[pc[7:2]] : 32'h0000_0013;

    core_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst         (inst),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .halt         (halt),
        .halt_code    (halt_code)
    );

    function automatic logic [31:0] r_format(input int f7, input int rs2, input int rs1,
                                             input int f3, input int rd,
                                             input logic [6:0] opc);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] i_format(input int imm, input int rs1, input int f3,
                                             input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_format(input int imm, input int rs2, input int rs1,
                                             input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_format(input int imm, input int rs2, input int rs1,
                                             input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] u_format(input int imm, input int rd,
                                             input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] j_format(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // places the word at the current pc and records what it should retire
    task automatic add_row(input logic [31:0] word, input logic valid, input int rd,
                           input logic [`XLEN-1:0] data);
        prog[at[7:2]] = word;
        exp_pc[n_rows] = at;
        exp_valid[n_rows] = valid;
        exp_rd[n_rows] = rd[4:0];
        exp_data[n_rows] = data;
        n_rows = n_rows + 1;
        at = at + 64'd4;
    endtask

    task automatic build_table();
        at = 64'h0;
        n_rows = 0;
        // arithmetic, compares, shifts, W forms
        add_row(u_format(32'h12345, 1, OPC_LUI), 1'b1, 1, 64'h0000_0000_1234_5000);
        add_row(i_format(32'h678, 1, 0, 1, OPC_IMM), 1'b1, 1, 64'h0000_0000_1234_5678);
        add_row(i_format(-5, 0, 0, 2, OPC_IMM), 1'b1, 2, 64'hFFFF_FFFF_FFFF_FFFB);
        add_row(r_format(0, 2, 1, 0, 3, OPC_OP), 1'b1, 3, 64'h0000_0000_1234_5673);
        add_row(r_format(32, 1, 2, 0, 4, OPC_OP), 1'b1, 4, 64'hFFFF_FFFF_EDCB_A983);
        add_row(r_format(0, 1, 2, 2, 5, OPC_OP), 1'b1, 5, 64'h1);
        add_row(r_format(0, 1, 2, 3, 6, OPC_OP), 1'b1, 6, 64'h0);
        add_row(i_format(4, 0, 0, 8, OPC_IMM), 1'b1, 8, 64'h4);
        add_row(r_format(32, 8, 4, 5, 7, OPC_OP), 1'b1, 7, 64'hFFFF_FFFF_FEDC_BA98);
        add_row(u_format(32'h7FFFF, 9, OPC_LUI), 1'b1, 9, 64'h0000_0000_7FFF_F000);
        add_row(r_format(0, 9, 9, 0, 11, OPC_OP32), 1'b1, 11, 64'hFFFF_FFFF_FFFF_E000);
        add_row(u_format(1, 12, OPC_AUIPC), 1'b1, 12, 64'h0000_0000_0000_102C);
        // multiply and divide with zero divisors and signed operands
        add_row(r_format(1, 8, 1, 0, 13, OPC_OP), 1'b1, 13, 64'h0000_0000_48D1_59E0);
        add_row(r_format(1, 8, 9, 0, 14, OPC_OP32), 1'b1, 14, 64'hFFFF_FFFF_FFFF_C000);
        add_row(r_format(1, 8, 1, 5, 15, OPC_OP), 1'b1, 15, 64'h0000_0000_048D_159E);
        add_row(r_format(1, 8, 3, 7, 16, OPC_OP), 1'b1, 16, 64'h3);
        add_row(r_format(1, 0, 1, 5, 17, OPC_OP), 1'b1, 17, 64'hFFFF_FFFF_FFFF_FFFF);
        add_row(r_format(1, 0, 1, 7, 18, OPC_OP), 1'b1, 18, 64'h0000_0000_1234_5678);
        add_row(r_format(1, 8, 4, 4, 19, OPC_OP32), 1'b1, 19, 64'hFFFF_FFFF_FB72_EA61);
        add_row(r_format(1, 8, 4, 6, 20, OPC_OP32), 1'b1, 20, 64'hFFFF_FFFF_FFFF_FFFF);
        add_row(r_format(1, 0, 2, 4, 21, OPC_OP32), 1'b1, 21, 64'hFFFF_FFFF_FFFF_FFFF);
        add_row(r_format(1, 0, 1, 6, 22, OPC_OP32), 1'b1, 22, 64'h0000_0000_1234_5678);
        // stores around 0x100, then loads of the merged bytes
        add_row(i_format(32'h100, 0, 0, 23, OPC_IMM), 1'b1, 23, 64'h100);
        add_row(s_format(0, 4, 23, 3), 1'b0, 0, 64'h0);
        add_row(s_format(8, 1, 23, 2), 1'b0, 0, 64'h0);
        add_row(s_format(12, 1, 23, 2), 1'b0, 0, 64'h0);
        add_row(s_format(2, 1, 23, 1), 1'b0, 0, 64'h0);
        add_row(s_format(5, 2, 23, 0), 1'b0, 0, 64'h0);
        add_row(s_format(9, 8, 23, 0), 1'b0, 0, 64'h0);
        add_row(i_format(0, 23, 3, 24, OPC_LOAD), 1'b1, 24, 64'hFFFF_FBFF_5678_A983);
        add_row(i_format(0, 23, 0, 25, OPC_LOAD), 1'b1, 25, 64'hFFFF_FFFF_FFFF_FF83);
        add_row(i_format(5, 23, 4, 26, OPC_LOAD), 1'b1, 26, 64'hFB);
        add_row(i_format(0, 23, 1, 27, OPC_LOAD), 1'b1, 27, 64'hFFFF_FFFF_FFFF_A983);
        add_row(i_format(2, 23, 5, 28, OPC_LOAD), 1'b1, 28, 64'h5678);
        add_row(i_format(4, 23, 2, 29, OPC_LOAD), 1'b1, 29, 64'hFFFF_FFFF_FFFF_FBFF);
        add_row(i_format(4, 23, 6, 30, OPC_LOAD), 1'b1, 30, 64'h0000_0000_FFFF_FBFF);
        add_row(i_format(8, 23, 3, 31, OPC_LOAD), 1'b1, 31, 64'h1234_5678_1234_0478);
        // each branch type once not taken and once taken
        add_row(b_format(8, 6, 5, 0), 1'b0, 0, 64'h0);
        add_row(b_format(8, 0, 6, 0), 1'b0, 0, 64'h0);
        at = 64'hA0;
        add_row(b_format(8, 6, 5, 1), 1'b0, 0, 64'h0);
        at = 64'hA8;
        add_row(b_format(8, 0, 6, 1), 1'b0, 0, 64'h0);
        add_row(b_format(8, 1, 2, 4), 1'b0, 0, 64'h0);
        at = 64'hB4;
        add_row(b_format(8, 2, 1, 4), 1'b0, 0, 64'h0);
        add_row(b_format(8, 2, 1, 5), 1'b0, 0, 64'h0);
        at = 64'hC0;
        add_row(b_format(8, 1, 2, 5), 1'b0, 0, 64'h0);
        add_row(b_format(8, 2, 1, 6), 1'b0, 0, 64'h0);
        at = 64'hCC;
        add_row(b_format(8, 1, 2, 6), 1'b0, 0, 64'h0);
        add_row(b_format(8, 1, 2, 7), 1'b0, 0, 64'h0);
        at = 64'hD8;
        add_row(b_format(8, 2, 1, 7), 1'b0, 0, 64'h0);
        // jal forward, jalr back with bit 0 set, jal with x0 link
        add_row(j_format(16, 1), 1'b1, 1, 64'hE0);
        at = 64'hEC;
        add_row(i_format(1, 1, 0, 5, OPC_JALR), 1'b1, 5, 64'hF0);
        at = 64'hE0;
        add_row(j_format(16, 0), 1'b0, 0, 64'h0);
        at = 64'hF0;
        add_row(i_format(32'h55, 5, 0, 0, OPC_IMM), 1'b0, 0, 64'h0);
        add_row(r_format(0, 0, 0, 6, 6, OPC_OP), 1'b1, 6, 64'h0);
        add_row(i_format(1, 0, 0, 10, OPC_IMM), 1'b1, 10, 64'h1);
        add_row(32'h0010_0073, 1'b0, 0, 64'h0);
        table_done = 1'b1;
    endtask

    initial begin
        rst_n = 1'b0;
        errors = 0;
        checks = 0;
        table_done = 1'b0;
        for (int a = 0; a < 64; a++) begin
            prog[a] = 32'h0;
        end
        build_table();
        last_pc = exp_pc[n_rows-1];
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            #(CLK_PERIOD / 4);
            checks = checks + 1;
            if (pc !== exp_pc[i]) begin
                $display("Fail pc at row %0d: expected %h, got %h", i, exp_pc[i], pc);
                errors++;
            end
            if (retire_valid !== exp_valid[i]) begin
                $display("Fail retire_valid at row %0d: expected %h, got %h",
                         i, exp_valid[i], retire_valid);
                errors++;
            end
            if (exp_valid[i] && retire_rd !== exp_rd[i]) begin
                $display("Fail retire_rd at row %0d: expected %h, got %h",
                         i, exp_rd[i], retire_rd);
                errors++;
            end
            if (exp_valid[i] && retire_data !== exp_data[i]) begin
                $display("Fail retire_data at row %0d: expected %h, got %h",
                         i, exp_data[i], retire_data);
                errors++;
            end
            if (halt !== 1'b0) begin
                $display("Fail halt at row %0d: expected 0, got %h", i, halt);
                errors++;
            end
            @(negedge clk);
        end
        // after EBREAK the core should sit still
        for (int k = 0; k < 3; k++) begin
            #(CLK_PERIOD / 4);
            checks = checks + 1;
            if (halt !== 1'b1) begin
                $display("Fail halt after ebreak: expected 1, got %h", halt);
                errors++;
            end
            if (halt_code !== 1'b1) begin
                $display("Fail halt_code after ebreak: expected 1, got %h", halt_code);
                errors++;
            end
            if (pc !== last_pc) begin
                $display("Fail pc after ebreak: expected %h, got %h", last_pc, pc);
                errors++;
            end
            if (retire_valid !== 1'b0) begin
                $display("Fail retire_valid after ebreak: expected 0, got %h", retire_valid);
                errors++;
            end
            @(negedge clk);
        end
        $display("checked %0d cycles, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // trace rows plus reset, the halted cycles and some slack
    initial begin
        wait (table_done);
        #((n_rows + RESET_CYCLES + 3 + 20) * CLK_PERIOD);
        $display("watchdog expired before the trace was finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+logic
logic/rv_pkg.sv
logic/inst_decode.sv
logic/reg_file.sv
logic/alu.sv
logic/lsu_align.sv
logic/data_ram.sv
logic/exec_unit.sv
logic/core_top.sv
tb/clock_gen.sv
tb/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the core testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module core_tb -f sources.f -o core_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/core_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0
